// ==== src/rv_pkg.sv ====
// shared widths and encodings; RV64I base integer only, with no W ops, CSRs or M extension
`default_nettype none

package rv_pkg;

	localparam int XLEN = 64;
	localparam int ADDR_W = 32; // byte address
	localparam int BE_W = XLEN / 8;
	localparam logic [ADDR_W-1:0] RESET_PC = '0;

	typedef enum logic [6:0] {
		LOAD   = 7'b0000011,
		OP_IMM = 7'b0010011,
		AUIPC  = 7'b0010111,
		STORE  = 7'b0100011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		BRANCH = 7'b1100011,
		JALR   = 7'b1100111,
		JAL    = 7'b1101111,
		SYSTEM = 7'b1110011
	} opcode_e;

	// load/store width codes
	localparam logic [2:0] F3_B = 3'd0;
	localparam logic [2:0] F3_H = 3'd1;
	localparam logic [2:0] F3_W = 3'd2;
	localparam logic [2:0] F3_D = 3'd3;
	localparam logic [2:0] F3_BU = 3'd4;
	localparam logic [2:0] F3_HU = 3'd5;
	localparam logic [2:0] F3_WU = 3'd6;

	localparam logic [2:0] F3_BEQ = 3'd0;
	localparam logic [2:0] F3_BNE = 3'd1;
	localparam logic [2:0] F3_BLT = 3'd4;
	localparam logic [2:0] F3_BGE = 3'd5;
	localparam logic [2:0] F3_BLTU = 3'd6;
	localparam logic [2:0] F3_BGEU = 3'd7;

	// OP and OP_IMM
	localparam logic [2:0] F3_ADD = 3'd0;
	localparam logic [2:0] F3_SLL = 3'd1;
	localparam logic [2:0] F3_SLT = 3'd2;
	localparam logic [2:0] F3_SLTU = 3'd3;
	localparam logic [2:0] F3_XOR = 3'd4;
	localparam logic [2:0] F3_SR = 3'd5;
	localparam logic [2:0] F3_OR = 3'd6;
	localparam logic [2:0] F3_AND = 3'd7;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,
		ALU_AND, ALU_PASS_B, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	typedef enum logic {OP1_REG, OP1_PC} op1_sel_e;
	typedef enum logic [1:0] {OP2_REG, OP2_IMM, OP2_FOUR} op2_sel_e;

	typedef enum logic [1:0] {WAIT_INST, EXEC, MEM_WAIT, HALT} ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/id_stage.sv ====
// RV64I base decode only; SYSTEM and unknown opcodes raise sys_halt, funct7 is checked only at bit 30
`default_nettype none
`timescale 1ns/1ps

module id_stage (
	input  logic [31:0] inst,
	output logic rs1_r_ena,
	output logic [4:0] rs1_r_addr,
	output logic rs2_r_ena,
	output logic [4:0] rs2_r_addr,
	output logic rd_w_ena,
	output logic [4:0] rd_w_addr,
	output rv_pkg::alu_op_e alu_op,
	output logic [rv_pkg::XLEN-1:0] imm,
	output rv_pkg::op1_sel_e op1_sel,
	output rv_pkg::op2_sel_e op2_sel,
	output logic branch,
	output logic jump,
	output logic pc_src, // 1 for jalr, target from rs1
	output logic mem_r_ena,
	output logic mem_w_ena,
	output logic [1:0] mem_size,
	output logic mem_ext_un,
	output logic sys_halt
);
	import rv_pkg::*;

	logic [2:0] funct3;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD: arith_op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL: arith_op = ALU_SLL;
			F3_SLT: arith_op = ALU_SLT;
			F3_SLTU: arith_op = ALU_SLTU;
			F3_XOR: arith_op = ALU_XOR;
			F3_SR: arith_op = alt ? ALU_SRA : ALU_SRL;
			F3_OR: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	assign funct3 = inst[14:12];
	assign rs1_r_addr = inst[19:15];
	assign rs2_r_addr = inst[24:20];
	assign rd_w_addr = inst[11:7];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign mem_size = funct3[1:0];
	assign mem_ext_un = mem_r_ena & (funct3 == F3_BU || funct3 == F3_HU || funct3 == F3_WU);

	always_comb begin
		rs1_r_ena = 1'b0;
		rs2_r_ena = 1'b0;
		rd_w_ena = 1'b0;
		alu_op = ALU_ADD;
		imm = imm_i;
		op1_sel = OP1_REG;
		op2_sel = OP2_IMM;
		branch = 1'b0;
		jump = 1'b0;
		pc_src = 1'b0;
		mem_r_ena = 1'b0;
		mem_w_ena = 1'b0;
		sys_halt = 1'b0;
		case (inst[6:0])
			OP_IMM: begin
				rs1_r_ena = 1'b1;
				rd_w_ena = 1'b1;
				alu_op = arith_op(funct3, inst[30] & (funct3 == F3_SR)); // only srai has alt
			end
			OP: begin
				rs1_r_ena = 1'b1;
				rs2_r_ena = 1'b1;
				rd_w_ena = 1'b1;
				op2_sel = OP2_REG;
				alu_op = arith_op(funct3, inst[30]);
			end
			LUI: begin
				rd_w_ena = 1'b1;
				imm = imm_u;
				alu_op = ALU_PASS_B;
			end
			AUIPC: begin
				rd_w_ena = 1'b1;
				imm = imm_u;
				op1_sel = OP1_PC;
			end
			JAL: begin
				rd_w_ena = 1'b1;
				jump = 1'b1;
				imm = imm_j;
				op1_sel = OP1_PC;
				op2_sel = OP2_FOUR; // link = pc + 4
			end
			JALR: begin
				rs1_r_ena = 1'b1;
				rd_w_ena = 1'b1;
				jump = 1'b1;
				pc_src = 1'b1;
				op1_sel = OP1_PC;
				op2_sel = OP2_FOUR;
			end
			BRANCH: begin
				rs1_r_ena = 1'b1;
				rs2_r_ena = 1'b1;
				branch = 1'b1;
				imm = imm_b;
				op2_sel = OP2_REG;
				case (funct3)
					F3_BNE: alu_op = ALU_BNE;
					F3_BLT: alu_op = ALU_BLT;
					F3_BGE: alu_op = ALU_BGE;
					F3_BLTU: alu_op = ALU_BLTU;
					F3_BGEU: alu_op = ALU_BGEU;
					default: alu_op = ALU_BEQ;
				endcase
			end
			LOAD: begin
				rs1_r_ena = 1'b1;
				rd_w_ena = 1'b1;
				mem_r_ena = 1'b1;
			end
			STORE: begin
				rs1_r_ena = 1'b1;
				rs2_r_ena = 1'b1;
				mem_w_ena = 1'b1;
				imm = imm_s;
			end
			SYSTEM: sys_halt = 1'b1; // ecall, ebreak
			default: sys_halt = 1'b1; // illegal opcode
		endcase
	end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
// 32 x XLEN registers, asynchronous read, x0 hardwired to zero
`default_nettype none
`timescale 1ns/1ps

module regfile (
	input  logic clk,
	input  logic arst_n,
	input  logic [4:0] rs1_addr,
	input  logic [4:0] rs2_addr,
	output logic [rv_pkg::XLEN-1:0] rs1_data,
	output logic [rv_pkg::XLEN-1:0] rs2_data,
	input  logic we,
	input  logic [4:0] rd_addr,
	input  logic [rv_pkg::XLEN-1:0] rd_data
);
	import rv_pkg::*;

	logic [XLEN-1:0] regs [0:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
// 64-bit integer ALU; shifts use the low 6 bits of b, branch ops drive only taken
`default_nettype none
`timescale 1ns/1ps

module alu (
	input  rv_pkg::alu_op_e op,
	input  logic [rv_pkg::XLEN-1:0] a,
	input  logic [rv_pkg::XLEN-1:0] b,
	output logic [rv_pkg::XLEN-1:0] result,
	output logic taken
);
	import rv_pkg::*;

	logic [5:0] shamt;

	assign shamt = b[5:0];

	always_comb begin
		result = '0;
		taken = 1'b0;
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_SLL: result = a << shamt;
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			ALU_PASS_B: result = b; // lui
			ALU_BEQ: taken = (a == b);
			ALU_BNE: taken = (a != b);
			ALU_BLT: taken = ($signed(a) < $signed(b));
			ALU_BGE: taken = ($signed(a) >= $signed(b));
			ALU_BLTU: taken = (a < b);
			ALU_BGEU: taken = (a >= b);
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
// PC and one-word buffer; a returned word is usable in its rvalid cycle, nothing is fetched when halted
`default_nettype none
`timescale 1ns/1ps

module fetch_unit (
	input  logic clk,
	input  logic arst_n,
	output logic fetch_req,
	output logic [rv_pkg::ADDR_W-1:0] fetch_addr,
	input  logic fetch_gnt,
	input  logic fetch_rvalid,
	input  logic [rv_pkg::XLEN-1:0] rdata,
	output logic inst_valid,
	output logic [31:0] inst,
	output logic [rv_pkg::ADDR_W-1:0] pc,
	input  logic inst_take,
	input  logic redirect,
	input  logic [rv_pkg::ADDR_W-1:0] redirect_pc,
	input  logic halt
);
	import rv_pkg::*;

	logic active; // first fetch one cycle after reset release
	logic buf_valid;
	logic pending; // read granted, data not back yet
	logic discard; // pending read belongs to an old pc
	logic [31:0] buf_q;
	logic [31:0] word;

	assign word = pc[2] ? rdata[63:32] : rdata[31:0];
	assign fetch_req = active & ~buf_valid & ~pending & ~halt;
	assign fetch_addr = pc;
	assign inst_valid = buf_valid | (fetch_rvalid & ~discard);
	assign inst = buf_valid ? buf_q : word;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			pc <= RESET_PC;
			buf_valid <= 1'b0;
			pending <= 1'b0;
			discard <= 1'b0;
		end else begin
			active <= 1'b1;
			if (fetch_gnt)
				pending <= 1'b1;
			else if (fetch_rvalid)
				pending <= 1'b0;
			if (redirect || inst_take) begin
				pc <= redirect ? redirect_pc : pc + ADDR_W'(4);
				buf_valid <= 1'b0;
				discard <= pending & ~fetch_rvalid;
			end else if (fetch_rvalid) begin
				buf_valid <= ~discard;
				discard <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_rvalid)
			buf_q <= word;
	end

endmodule

`default_nettype wire

// ==== src/lsu.sv ====
// aligned accesses only; request held until granted, load data shifted down from its byte lane
`default_nettype none
`timescale 1ns/1ps

module lsu (
	input  logic clk,
	input  logic arst_n,
	input  logic mem_start,
	input  logic is_store,
	input  logic [1:0] mem_size,
	input  logic mem_ext_un,
	input  logic [rv_pkg::ADDR_W-1:0] addr,
	input  logic [rv_pkg::XLEN-1:0] store_data,
	output logic lsu_req,
	output logic lsu_we,
	output logic [rv_pkg::ADDR_W-1:0] lsu_addr,
	output logic [rv_pkg::BE_W-1:0] lsu_be,
	output logic [rv_pkg::XLEN-1:0] lsu_wdata,
	input  logic lsu_gnt,
	input  logic lsu_rvalid,
	input  logic [rv_pkg::XLEN-1:0] rdata,
	output logic mem_done,
	output logic [rv_pkg::XLEN-1:0] load_data
);
	import rv_pkg::*;

	logic [1:0] size_q;
	logic un_q;
	logic [BE_W-1:0] size_mask;
	logic [XLEN-1:0] shifted;

	always_comb begin
		case (mem_size)
			F3_B[1:0]: size_mask = 8'h01;
			F3_H[1:0]: size_mask = 8'h03;
			F3_W[1:0]: size_mask = 8'h0f;
			default: size_mask = {BE_W{1'b1}}; // doubleword
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lsu_req <= 1'b0;
			lsu_we <= 1'b0;
		end else if (mem_start) begin
			lsu_req <= 1'b1;
			lsu_we <= is_store;
		end else if (lsu_gnt) begin
			lsu_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_start) begin
			lsu_addr <= addr;
			lsu_be <= size_mask << addr[2:0];
			lsu_wdata <= store_data << {addr[2:0], 3'b000};
			size_q <= mem_size;
			un_q <= mem_ext_un;
		end
	end

	assign mem_done = (lsu_gnt & lsu_we) | lsu_rvalid; // store done at grant
	assign shifted = rdata >> {lsu_addr[2:0], 3'b000};

	always_comb begin
		case (size_q)
			F3_B[1:0]: load_data = {{(XLEN-8){~un_q & shifted[7]}}, shifted[7:0]};
			F3_H[1:0]: load_data = {{(XLEN-16){~un_q & shifted[15]}}, shifted[15:0]};
			F3_W[1:0]: load_data = {{(XLEN-32){~un_q & shifted[31]}}, shifted[31:0]};
			F3_D[1:0]: load_data = shifted;
			default: load_data = shifted;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
// fixed priority, LSU over fetch; assumes read data one cycle after the strobe and no stalls
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter (
	input  logic clk,
	input  logic arst_n,
	input  logic fetch_req,
	input  logic [rv_pkg::ADDR_W-1:0] fetch_addr,
	output logic fetch_gnt,
	output logic fetch_rvalid,
	input  logic lsu_req,
	input  logic lsu_we,
	input  logic [rv_pkg::ADDR_W-1:0] lsu_addr,
	input  logic [rv_pkg::BE_W-1:0] lsu_be,
	input  logic [rv_pkg::XLEN-1:0] lsu_wdata,
	output logic lsu_gnt,
	output logic lsu_rvalid,
	output logic mem_req,
	output logic mem_we,
	output logic [rv_pkg::ADDR_W-1:0] mem_addr,
	output logic [rv_pkg::BE_W-1:0] mem_be,
	output logic [rv_pkg::XLEN-1:0] mem_wdata
);
	import rv_pkg::*;

	logic rd_pend;
	logic rd_lsu; // owner of the read in flight

	assign lsu_gnt = lsu_req;
	assign fetch_gnt = fetch_req & ~lsu_req;
	assign mem_req = lsu_req | fetch_req;
	assign mem_we = lsu_req & lsu_we;
	assign mem_addr = lsu_req ? lsu_addr : fetch_addr;
	assign mem_be = lsu_req ? lsu_be : {BE_W{1'b1}};
	assign mem_wdata = lsu_wdata; // fetch never writes

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pend <= 1'b0;
			rd_lsu <= 1'b0;
		end else begin
			rd_pend <= mem_req & ~mem_we;
			rd_lsu <= lsu_req;
		end
	end

	assign fetch_rvalid = rd_pend & ~rd_lsu;
	assign lsu_rvalid = rd_pend & rd_lsu;

endmodule

`default_nettype wire

// ==== src/exec_ctrl.sv ====
// one instruction at a time; a store retires at issue, a load keeps its word until writeback
`default_nettype none
`timescale 1ns/1ps

module exec_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic rd_w_ena,
	input  logic [rv_pkg::XLEN-1:0] imm,
	input  rv_pkg::op1_sel_e op1_sel,
	input  rv_pkg::op2_sel_e op2_sel,
	input  logic branch,
	input  logic jump,
	input  logic pc_src,
	input  logic mem_r_ena,
	input  logic mem_w_ena,
	input  logic sys_halt,
	input  logic inst_valid,
	input  logic [rv_pkg::ADDR_W-1:0] pc,
	output logic inst_take,
	input  logic [rv_pkg::XLEN-1:0] rs1_data,
	input  logic [rv_pkg::XLEN-1:0] rs2_data,
	output logic [rv_pkg::XLEN-1:0] alu_a,
	output logic [rv_pkg::XLEN-1:0] alu_b,
	input  logic [rv_pkg::XLEN-1:0] alu_result,
	input  logic alu_taken,
	output logic rf_we,
	output logic [rv_pkg::XLEN-1:0] rf_wdata,
	output logic redirect,
	output logic [rv_pkg::ADDR_W-1:0] redirect_pc,
	output logic mem_start,
	input  logic mem_done,
	input  logic [rv_pkg::XLEN-1:0] load_data,
	output logic halted
);
	import rv_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	logic ld_q; // MEM_WAIT is for a load
	logic in_exec;
	logic ld_done;
	logic [XLEN-1:0] pc_x;
	logic [XLEN-1:0] target;

	assign pc_x = {{(XLEN-ADDR_W){1'b0}}, pc};
	assign in_exec = (state == EXEC);
	assign ld_done = (state == MEM_WAIT) & ld_q & mem_done;

	assign alu_a = (op1_sel == OP1_PC) ? pc_x : rs1_data;

	always_comb begin
		case (op2_sel)
			OP2_REG: alu_b = rs2_data;
			OP2_FOUR: alu_b = XLEN'(4);
			default: alu_b = imm;
		endcase
	end

	assign target = pc_src ? ((rs1_data + imm) & ~XLEN'(1)) : pc_x + imm;
	assign redirect = in_exec & (jump | (branch & alu_taken));
	assign redirect_pc = target[ADDR_W-1:0];
	assign mem_start = in_exec & (mem_r_ena | mem_w_ena);
	assign inst_take = (in_exec & ~sys_halt & ~mem_r_ena & ~redirect) | ld_done;
	assign rf_we = (in_exec & rd_w_ena & ~mem_r_ena) | ld_done;
	assign rf_wdata = (state == MEM_WAIT) ? load_data : alu_result;
	assign halted = (state == HALT);

	always_comb begin
		state_nxt = state;
		case (state)
			WAIT_INST: begin
				if (inst_valid)
					state_nxt = EXEC;
			end
			EXEC: begin
				if (sys_halt)
					state_nxt = HALT;
				else if (mem_r_ena || mem_w_ena)
					state_nxt = MEM_WAIT;
				else
					state_nxt = WAIT_INST;
			end
			MEM_WAIT: begin
				if (mem_done)
					state_nxt = WAIT_INST;
			end
			HALT: state_nxt = HALT; // until reset
			default: state_nxt = WAIT_INST;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= WAIT_INST;
			ld_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (mem_start)
				ld_q <= mem_r_ena;
		end
	end

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
// multicycle RV64I core with one shared 64-bit memory port; read data is expected one cycle after mem_req
`default_nettype none
`timescale 1ns/1ps

module rv_core (
	input  logic clk,
	input  logic arst_n,
	output logic mem_req,
	output logic mem_we,
	output logic [rv_pkg::ADDR_W-1:0] mem_addr,
	output logic [rv_pkg::BE_W-1:0] mem_be,
	output logic [rv_pkg::XLEN-1:0] mem_wdata,
	input  logic [rv_pkg::XLEN-1:0] mem_rdata,
	output logic halted
);
	import rv_pkg::*;

	logic [31:0] inst;
	logic inst_valid, inst_take, redirect;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] redirect_pc;
	logic fetch_req, fetch_gnt, fetch_rvalid;
	logic [ADDR_W-1:0] fetch_addr;
	logic rs1_r_ena, rs2_r_ena, rd_w_ena;
	logic [4:0] rs1_r_addr, rs2_r_addr, rd_w_addr;
	logic [4:0] rs1_addr, rs2_addr;
	alu_op_e alu_op;
	op1_sel_e op1_sel;
	op2_sel_e op2_sel;
	logic [XLEN-1:0] imm;
	logic branch, jump, pc_src, sys_halt;
	logic mem_r_ena, mem_w_ena, mem_ext_un;
	logic [1:0] mem_size;
	logic [XLEN-1:0] rs1_data, rs2_data, rf_wdata;
	logic rf_we;
	logic [XLEN-1:0] alu_a, alu_b, alu_result;
	logic alu_taken;
	logic mem_start, mem_done;
	logic [XLEN-1:0] load_data;
	logic lsu_req, lsu_we, lsu_gnt, lsu_rvalid;
	logic [ADDR_W-1:0] lsu_addr;
	logic [BE_W-1:0] lsu_be;
	logic [XLEN-1:0] lsu_wdata;

	assign rs1_addr = rs1_r_ena ? rs1_r_addr : 5'd0; // unused source reads x0
	assign rs2_addr = rs2_r_ena ? rs2_r_addr : 5'd0;

	fetch_unit fetch_unit_inst (
		.clk(clk), .arst_n(arst_n), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_gnt(fetch_gnt), .fetch_rvalid(fetch_rvalid), .rdata(mem_rdata),
		.inst_valid(inst_valid), .inst(inst), .pc(pc), .inst_take(inst_take),
		.redirect(redirect), .redirect_pc(redirect_pc), .halt(halted)
	);

	id_stage id_stage_inst (
		.inst(inst), .rs1_r_ena(rs1_r_ena), .rs1_r_addr(rs1_r_addr),
		.rs2_r_ena(rs2_r_ena), .rs2_r_addr(rs2_r_addr), .rd_w_ena(rd_w_ena),
		.rd_w_addr(rd_w_addr), .alu_op(alu_op), .imm(imm), .op1_sel(op1_sel),
		.op2_sel(op2_sel), .branch(branch), .jump(jump), .pc_src(pc_src),
		.mem_r_ena(mem_r_ena), .mem_w_ena(mem_w_ena), .mem_size(mem_size),
		.mem_ext_un(mem_ext_un), .sys_halt(sys_halt)
	);

	regfile regfile_inst (
		.clk(clk), .arst_n(arst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .we(rf_we), .rd_addr(rd_w_addr),
		.rd_data(rf_wdata)
	);

	alu alu_inst (
		.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .taken(alu_taken)
	);

	exec_ctrl exec_ctrl_inst (
		.clk(clk), .arst_n(arst_n), .rd_w_ena(rd_w_ena), .imm(imm), .op1_sel(op1_sel),
		.op2_sel(op2_sel), .branch(branch), .jump(jump), .pc_src(pc_src),
		.mem_r_ena(mem_r_ena), .mem_w_ena(mem_w_ena), .sys_halt(sys_halt),
		.inst_valid(inst_valid), .pc(pc), .inst_take(inst_take), .rs1_data(rs1_data),
		.rs2_data(rs2_data), .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result),
		.alu_taken(alu_taken), .rf_we(rf_we), .rf_wdata(rf_wdata), .redirect(redirect),
		.redirect_pc(redirect_pc), .mem_start(mem_start), .mem_done(mem_done),
		.load_data(load_data), .halted(halted)
	);

	lsu lsu_inst (
		.clk(clk), .arst_n(arst_n), .mem_start(mem_start), .is_store(mem_w_ena),
		.mem_size(mem_size), .mem_ext_un(mem_ext_un), .addr(alu_result[ADDR_W-1:0]),
		.store_data(rs2_data), .lsu_req(lsu_req), .lsu_we(lsu_we), .lsu_addr(lsu_addr),
		.lsu_be(lsu_be), .lsu_wdata(lsu_wdata), .lsu_gnt(lsu_gnt),
		.lsu_rvalid(lsu_rvalid), .rdata(mem_rdata), .mem_done(mem_done),
		.load_data(load_data)
	);

	mem_arbiter mem_arbiter_inst (
		.clk(clk), .arst_n(arst_n), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_gnt(fetch_gnt), .fetch_rvalid(fetch_rvalid), .lsu_req(lsu_req),
		.lsu_we(lsu_we), .lsu_addr(lsu_addr), .lsu_be(lsu_be), .lsu_wdata(lsu_wdata),
		.lsu_gnt(lsu_gnt), .lsu_rvalid(lsu_rvalid), .mem_req(mem_req), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_be(mem_be), .mem_wdata(mem_wdata)
	);

endmodule

`default_nettype wire

// ==== test/rv_core_props.sv ====
// bus and halt rules of the core; bound into rv_core, where the arbiter grant nets are visible
`default_nettype none
`timescale 1ns/1ps

module rv_core_props (
	input logic clk,
	input logic arst_n,
	input logic mem_req,
	input logic mem_we,
	input logic halted,
	input logic fetch_req,
	input logic fetch_gnt,
	input logic lsu_gnt
);
	int fail_cnt = 0; // failed assertions so far

	one_grant: assert property (@(posedge clk) disable iff (!arst_n) !(fetch_gnt && lsu_gnt))
	else begin
		$error("fetch and LSU granted in the same cycle");
		fail_cnt++;
	end

	quiet_after_reset: assert property (@(posedge clk)
		(!arst_n || $rose(arst_n)) |-> (!mem_req && !mem_we && !halted))
	else begin
		$error("memory port or halted active in or right after reset");
		fail_cnt++;
	end

	no_req_halted: assert property (@(posedge clk) disable iff (!arst_n) halted |-> !mem_req)
	else begin
		$error("memory request while halted");
		fail_cnt++;
	end

	fetch_holds: assert property (@(posedge clk) disable iff (!arst_n)
		(fetch_req && !fetch_gnt) |=> fetch_req)
	else begin
		$error("refused fetch request was withdrawn");
		fail_cnt++;
	end

endmodule

bind rv_core rv_core_props rv_core_props_inst (
	.clk(clk), .arst_n(arst_n), .mem_req(mem_req), .mem_we(mem_we), .halted(halted),
	.fetch_req(fetch_req), .fetch_gnt(fetch_gnt), .lsu_gnt(lsu_gnt)
);

`default_nettype wire

// ==== test/rv_core_tb.sv ====
// memory model covers 1 KiB only, answers a read one cycle after mem_req and never stalls
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb;

	localparam logic [31:0] OPA_ADDR = 32'h300;
	localparam logic [31:0] OPB_ADDR = 32'h308;
	localparam logic [31:0] KNOWN_ADDR = 32'h310;
	localparam logic [31:0] RES_ADDR = 32'h340;
	localparam logic [31:0] POISON = 32'h3f8; // only skipped paths store here

	logic clk;
	logic arst_n;
	logic mem_req;
	logic mem_we;
	logic [31:0] mem_addr;
	logic [7:0] mem_be;
	logic [63:0] mem_wdata;
	logic [63:0] mem_rdata;
	logic halted;

	logic [63:0] mem [0:127];
	logic rd_pend;
	logic [6:0] rd_idx;

	// expected stores, in program order
	string exp_name [$];
	logic [31:0] exp_addr [$];
	logic [7:0] exp_be [$];
	logic [63:0] exp_data [$];

	integer seed;
	int errors;
	int checked;
	int slot;
	logic [31:0] pc;
	logic [63:0] op_a;
	logic [63:0] op_b;
	logic [63:0] known;

	rv_core rv_core_inst (
		.clk(clk), .arst_n(arst_n), .mem_req(mem_req), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_be(mem_be), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .halted(halted)
	);

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [63:0] lane_mask(input logic [7:0] be);
		logic [63:0] m;
		for (int i = 0; i < 8; i++)
			m[i*8 +: 8] = {8{be[i]}};
		return m;
	endfunction

	// sign or zero extension of the low nbytes
	function automatic logic [63:0] extend(input logic [63:0] v, input int nbytes, input bit un);
		logic [63:0] m;
		m = (nbytes == 8) ? '1 : ((64'd1 << (nbytes * 8)) - 64'd1);
		if (!un && nbytes < 8 && v[nbytes*8-1])
			return v | ~m;
		return v & m;
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[pc[9:3]][{pc[2], 5'd0} +: 32] = word;
		pc += 4;
	endtask

	task automatic emit_poison();
		emit(stype(POISON[11:0], 5'd0, 5'd0, 3'd3)); // sd x0
	endtask

	task automatic expect_store(input string name, input logic [31:0] addr,
			input logic [7:0] be, input logic [63:0] data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_be.push_back(be);
		exp_data.push_back(data);
	endtask

	task automatic store_result(input string name, input logic [4:0] rs,
			input logic [63:0] value);
		logic [31:0] addr;
		addr = RES_ADDR + 32'(8 * (slot % 16));
		emit(stype(addr[11:0], rs, 5'd0, 3'd3));
		expect_store(name, addr, 8'hff, value);
		slot++;
	endtask

	task automatic op_test(input string name, input logic [6:0] f7, input logic [2:0] f3,
			input logic [63:0] value);
		emit(rtype(f7, 5'd2, 5'd1, f3, 5'd5));
		store_result(name, 5'd5, value);
	endtask

	task automatic imm_test(input string name, input logic [2:0] f3, input logic [11:0] imm,
			input logic [63:0] value);
		emit(itype(imm, 5'd1, f3, 5'd5, 7'h13));
		store_result(name, 5'd5, value);
	endtask

	task automatic load_test(input string name, input logic [2:0] f3, input int nbytes,
			input bit un, input int off);
		emit(itype(12'(KNOWN_ADDR + off), 5'd0, f3, 5'd5, 7'h03));
		store_result($sformatf("%s@%0d", name, off), 5'd5,
			extend(known >> (off * 8), nbytes, un));
	endtask

	task automatic part_store(input string name, input logic [2:0] f3, input int nbytes,
			input logic [31:0] addr);
		logic [7:0] be;
		be = 8'((16'd1 << nbytes) - 16'd1) << addr[2:0];
		emit(stype(addr[11:0], 5'd2, 5'd0, f3));
		expect_store(name, addr, be, (op_b << (addr[2:0] * 8)) & lane_mask(be));
	endtask

	task automatic branch_test(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input bit taken);
		emit(btype(13'd8, rs2, rs1, f3));
		if (!taken)
			emit(jtype(21'd8, 5'd0)); // hop over the poison store
		emit_poison();
	endtask

	task automatic check_write();
		string name;
		logic [31:0] addr;
		logic [7:0] be;
		logic [63:0] data;
		assert (mem_addr != POISON) else begin
			$display("a store from a skipped path reached the poison address");
			errors++;
		end
		assert (mem_addr == POISON || exp_addr.size() > 0) else begin
			$display("unexpected store to address %h after the last expected one", mem_addr);
			errors++;
		end
		if (mem_addr != POISON && exp_addr.size() > 0) begin
			name = exp_name.pop_front();
			addr = exp_addr.pop_front();
			be = exp_be.pop_front();
			data = exp_data.pop_front();
			assert (mem_addr == addr) else begin
				$display("ERROR %s: expected address %h, actual %h", name, addr, mem_addr);
				errors++;
			end
			assert (mem_be == be) else begin
				$display("ERROR %s: expected mem_be %h, actual %h", name, be, mem_be);
				errors++;
			end
			assert ((mem_wdata & lane_mask(be)) == data) else begin
				$display("ERROR %s: expected %h, actual %h", name, data,
					mem_wdata & lane_mask(be));
				errors++;
			end
			checked++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory port sampled mid-cycle, read data driven just after the next edge
	always @(negedge clk) begin
		rd_pend = arst_n && mem_req && !mem_we;
		rd_idx = mem_addr[9:3];
		if (arst_n && mem_req && mem_we) begin
			check_write();
			for (int i = 0; i < 8; i++)
				if (mem_be[i])
					mem[mem_addr[9:3]][i*8 +: 8] = mem_wdata[i*8 +: 8];
		end
	end

	always @(posedge clk) begin
		#1;
		if (rd_pend)
			mem_rdata = mem[rd_idx];
	end

	initial begin
		logic [11:0] imm;
		logic [63:0] iv;
		logic [5:0] sh;
		logic [19:0] up;
		logic [31:0] here;
		int limit;
		int cycles;
		arst_n = 1'b0;
		mem_rdata = '0;
		rd_pend = 1'b0;
		errors = 0;
		checked = 0;
		slot = 0;
		pc = '0;
		seed = 32'h2465_d873;
		for (int i = 0; i < 128; i++)
			mem[i] = {~(32'(i) << 3), 32'(i) << 3}; // from the byte address
		op_a = {$random(seed), $random(seed)};
		op_b = {$random(seed), $random(seed)};
		known = ({$random(seed), $random(seed)} | 64'h8000_0000_0000_0000) & ~64'h8000_0000;
		mem[OPA_ADDR[9:3]] = op_a;
		mem[OPB_ADDR[9:3]] = op_b;
		mem[KNOWN_ADDR[9:3]] = known;

		emit(itype(OPA_ADDR[11:0], 5'd0, 3'd3, 5'd1, 7'h03));
		emit(itype(OPB_ADDR[11:0], 5'd0, 3'd3, 5'd2, 7'h03));
		emit(itype(12'hfff, 5'd0, 3'd0, 5'd3, 7'h13)); // x3 = -1
		emit(itype(12'h001, 5'd0, 3'd0, 5'd4, 7'h13)); // x4 = 1
		op_test("add", 7'h00, 3'd0, op_a + op_b);
		op_test("sub", 7'h20, 3'd0, op_a - op_b);
		op_test("sll", 7'h00, 3'd1, op_a << op_b[5:0]);
		op_test("slt", 7'h00, 3'd2, {63'd0, $signed(op_a) < $signed(op_b)});
		op_test("sltu", 7'h00, 3'd3, {63'd0, op_a < op_b});
		op_test("xor", 7'h00, 3'd4, op_a ^ op_b);
		op_test("srl", 7'h00, 3'd5, op_a >> op_b[5:0]);
		op_test("sra", 7'h20, 3'd5, $signed(op_a) >>> op_b[5:0]);
		op_test("or", 7'h00, 3'd6, op_a | op_b);
		op_test("and", 7'h00, 3'd7, op_a & op_b);
		imm = 12'($random(seed));
		iv = {{52{imm[11]}}, imm};
		imm_test("addi", 3'd0, imm, op_a + iv);
		imm_test("slti", 3'd2, imm, {63'd0, $signed(op_a) < $signed(iv)});
		imm_test("sltiu", 3'd3, imm, {63'd0, op_a < iv});
		imm_test("xori", 3'd4, imm, op_a ^ iv);
		imm_test("ori", 3'd6, imm, op_a | iv);
		imm_test("andi", 3'd7, imm, op_a & iv);
		sh = 6'($random(seed));
		imm_test("slli", 3'd1, {6'h00, sh}, op_a << sh);
		imm_test("srli", 3'd5, {6'h00, sh}, op_a >> sh);
		imm_test("srai", 3'd5, {6'h10, sh}, $signed(op_a) >>> sh);
		up = 20'($random(seed));
		emit(utype(up, 5'd5, 7'h37));
		store_result("lui", 5'd5, {{32{up[19]}}, up, 12'h000});
		here = pc;
		emit(utype(up, 5'd5, 7'h17));
		store_result("auipc", 5'd5, {32'h0, here} + {{32{up[19]}}, up, 12'h000});

		load_test("lb", 3'd0, 1, 1'b0, 3);
		load_test("lb", 3'd0, 1, 1'b0, 7);
		load_test("lbu", 3'd4, 1, 1'b1, 3);
		load_test("lbu", 3'd4, 1, 1'b1, 7);
		load_test("lh", 3'd1, 2, 1'b0, 2);
		load_test("lh", 3'd1, 2, 1'b0, 6);
		load_test("lhu", 3'd5, 2, 1'b1, 2);
		load_test("lhu", 3'd5, 2, 1'b1, 6);
		load_test("lw", 3'd2, 4, 1'b0, 0);
		load_test("lw", 3'd2, 4, 1'b0, 4);
		load_test("lwu", 3'd6, 4, 1'b1, 0);
		load_test("lwu", 3'd6, 4, 1'b1, 4);
		load_test("ld", 3'd3, 8, 1'b0, 0);

		// back to back stores while the next fetch waits
		for (int off = 0; off < 8; off++)
			part_store($sformatf("sb@%0d", off), 3'd0, 1, 32'h318 + off);
		for (int off = 0; off < 8; off += 2)
			part_store($sformatf("sh@%0d", off), 3'd1, 2, 32'h320 + off);
		for (int off = 0; off < 8; off += 4)
			part_store($sformatf("sw@%0d", off), 3'd2, 4, 32'h328 + off);
		part_store("sh@6 known", 3'd1, 2, KNOWN_ADDR + 6);
		emit(itype(KNOWN_ADDR[11:0], 5'd0, 3'd3, 5'd5, 7'h03));
		store_result("sh merge", 5'd5, {op_b[15:0], known[47:0]});

		branch_test(3'd0, 5'd0, 5'd0, 1'b1); // beq
		branch_test(3'd0, 5'd0, 5'd4, 1'b0);
		branch_test(3'd1, 5'd0, 5'd4, 1'b1); // bne
		branch_test(3'd1, 5'd4, 5'd4, 1'b0);
		branch_test(3'd4, 5'd3, 5'd0, 1'b1); // blt, -1 < 0
		branch_test(3'd4, 5'd0, 5'd3, 1'b0);
		branch_test(3'd5, 5'd0, 5'd3, 1'b1); // bge
		branch_test(3'd5, 5'd3, 5'd0, 1'b0);
		branch_test(3'd6, 5'd0, 5'd3, 1'b1); // bltu, -1 is the largest unsigned
		branch_test(3'd6, 5'd3, 5'd0, 1'b0);
		branch_test(3'd7, 5'd3, 5'd0, 1'b1); // bgeu
		branch_test(3'd7, 5'd0, 5'd3, 1'b0);
		here = pc;
		emit(jtype(21'd8, 5'd5));
		emit_poison();
		store_result("jal link", 5'd5, 64'(here + 4));
		here = pc;
		emit(utype(20'h0, 5'd6, 7'h17));
		emit(itype(12'd13, 5'd6, 3'd0, 5'd7, 7'h67)); // odd target, bit 0 dropped
		emit_poison();
		store_result("jalr link", 5'd7, 64'(here + 8));
		emit(32'h0000_0073); // ecall

		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
		limit = (pc / 4) * 8 + 200;
		cycles = 0;
		while (!halted && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("timeout: core did not halt within %0d cycles", limit);
			errors++;
		end else begin
			repeat (10) @(negedge clk); // bus must stay idle once halted
		end
		assert (exp_addr.size() == 0) else begin
			$display("%0d expected stores never happened, first missing is %s",
				exp_addr.size(), exp_name[0]);
			errors++;
		end
		$display("%0d stores checked, %0d errors, %0d assertion failures", checked, errors,
			rv_core_inst.rv_core_props_inst.fail_cnt);
		if (errors == 0 && rv_core_inst.rv_core_props_inst.fail_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rv_core.f ====
src/rv_pkg.sv
src/id_stage.sv
src/regfile.sv
src/alu.sv
src/fetch_unit.sv
src/lsu.sv
src/mem_arbiter.sv
src/exec_ctrl.sv
src/rv_core.sv
test/rv_core_props.sv
test/rv_core_tb.sv
